// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_llc
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f verilog.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)

// File: llc_cfg_pkg.sv
package llc_cfg_pkg;

    localparam int llc_ways       = 4;
    localparam int llc_sets       = 16;
    localparam int llc_set_bits   = 4;
    localparam int llc_tag_bits   = 8;
    localparam int llc_way_bits   = 2;
    localparam int line_bits      = 128;  // Four 32-bit words
    localparam int line_addr_bits = llc_tag_bits + llc_set_bits;

    typedef logic [line_addr_bits-1:0] line_addr_t;
    typedef logic [llc_tag_bits-1:0]   llc_tag_t;
    typedef logic [llc_set_bits-1:0]   llc_set_t;
    typedef logic [llc_way_bits-1:0]   llc_way_t;
    typedef logic [line_bits-1:0]      line_t;

    // Line address, either raw or split as tag over set index
    typedef union packed {
        line_addr_t raw;
        struct packed {
            llc_tag_t tag;
            llc_set_t set;
        } f;
    } line_addr_u;

endpackage

// File: llc_ctrl.sv
`timescale 1ns/1ps

module llc_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  llc_msg_pkg::req_op_t    req_op_i,
    input  llc_cfg_pkg::line_addr_t req_addr_i,
    input  llc_cfg_pkg::line_t      req_line_i,
    input  llc_msg_pkg::req_id_t    req_id_i,
    output logic                    rsp_valid_o,
    input  logic                    rsp_ready_i,
    output llc_cfg_pkg::line_t      rsp_line_o,
    output llc_msg_pkg::req_id_t    rsp_id_o,
    output logic                    mem_req_valid_o,
    input  logic                    mem_req_ready_i,
    output logic                    mem_req_write_o,
    output llc_cfg_pkg::line_addr_t mem_req_addr_o,
    output llc_cfg_pkg::line_t      mem_req_line_o,
    input  logic                    mem_rsp_valid_i,
    output logic                    mem_rsp_ready_o,
    output llc_msg_pkg::llc_state_t state_o,
    output llc_cfg_pkg::llc_set_t   set_o,
    output llc_cfg_pkg::llc_tag_t   tag_o,
    output llc_cfg_pkg::llc_way_t   way_o,
    output logic                    buf_wr_o,
    output llc_cfg_pkg::line_t      buf_wr_line_o,
    output logic                    buf_wr_dirty_o,
    output logic                    fill_o,
    input  logic                    hit_i,
    input  llc_cfg_pkg::llc_way_t   hit_way_i,
    input  llc_cfg_pkg::llc_way_t   victim_way_i,
    input  logic                    victim_dirty_i,
    input  llc_cfg_pkg::llc_tag_t   buf_tag_i,
    input  llc_cfg_pkg::line_t      buf_line_i,
    output logic                    repl_o
);
    import llc_cfg_pkg::*;
    import llc_msg_pkg::*;

    llc_state_t state, next_state;
    req_op_t    op_q;
    line_addr_u addr_q;
    line_t      line_q;
    req_id_t    id_q;
    line_addr_u wb_addr;
    llc_way_t   way_q;
    logic       miss_q;
    logic       wb_pend;    // Dirty victim still to be written back
    logic       rd_pend;    // Fill request still to be issued
    logic       fill_wait;  // Waiting for fill data
    logic       buf_pend;   // Tag/line still to be written into the buffer
    logic       in_process;
    logic       mem_req_go;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= st_decode;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_decode:   if (req_valid_i) next_state = st_read_set;
            st_read_set: next_state = st_read_mem;
            st_read_mem: next_state = st_lookup;
            st_lookup:   next_state = st_process;
            st_process:  if (rsp_valid_o && rsp_ready_i) next_state = st_update;
            st_update:   next_state = st_decode;
            default:     next_state = st_decode;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            op_q       <= req_op_i;
            addr_q.raw <= req_addr_i;
            line_q     <= req_line_i;
            id_q       <= req_id_i;
        end
    end

    // Steps of PROCESS, planned from the lookup result
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            way_q     <= '0;
            miss_q    <= 1'b0;
            wb_pend   <= 1'b0;
            rd_pend   <= 1'b0;
            fill_wait <= 1'b0;
            buf_pend  <= 1'b0;
        end else if (state == st_lookup) begin
            way_q    <= hit_i ? hit_way_i : victim_way_i;
            miss_q   <= !hit_i;
            wb_pend  <= !hit_i && victim_dirty_i;
            rd_pend  <= !hit_i && (op_q == op_read);
            buf_pend <= !hit_i || (op_q == op_write);
        end else if (in_process) begin
            if (mem_req_go && wb_pend) begin
                wb_pend <= 1'b0;
            end else if (mem_req_go) begin
                rd_pend   <= 1'b0;
                fill_wait <= 1'b1;
            end
            if (fill_o) fill_wait <= 1'b0;
            if (buf_wr_o) buf_pend <= 1'b0;
        end
    end

    // Victim goes back to its own tag in the current set
    always_comb begin
        wb_addr.f.tag = buf_tag_i;
        wb_addr.f.set = addr_q.f.set;
    end

    assign in_process = (state == st_process);
    assign mem_req_go = mem_req_valid_o && mem_req_ready_i;

    assign state_o = state;
    assign set_o   = addr_q.f.set;
    assign tag_o   = addr_q.f.tag;
    assign way_o   = way_q;
    assign repl_o  = miss_q;

    assign req_ready_o     = (state == st_decode);
    assign mem_req_valid_o = in_process && (wb_pend || rd_pend);
    assign mem_req_write_o = wb_pend;
    assign mem_req_addr_o  = wb_pend ? wb_addr.raw : addr_q.raw;
    assign mem_req_line_o  = buf_line_i;
    assign mem_rsp_ready_o = in_process && fill_wait;
    assign fill_o          = mem_rsp_valid_i && mem_rsp_ready_o;

    assign buf_wr_o       = in_process && buf_pend && !wb_pend && !rd_pend && !fill_wait;
    assign buf_wr_line_o  = (op_q == op_write) ? line_q : buf_line_i;  // Fill data on a read
    assign buf_wr_dirty_o = (op_q == op_write);

    assign rsp_valid_o = in_process && !buf_pend && !wb_pend && !rd_pend && !fill_wait;
    assign rsp_line_o  = (op_q == op_read) ? buf_line_i : '0;
    assign rsp_id_o    = id_q;

    a_rsp_stable: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid_o && !rsp_ready_i |=>
            rsp_valid_o && $stable(rsp_line_o) && $stable(rsp_id_o))
        else $error("response changed under back-pressure");

    a_mem_req_stable: assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid_o && !mem_req_ready_i |=>
            mem_req_valid_o && $stable(mem_req_write_o) && $stable(mem_req_addr_o)
            && (!mem_req_write_o || $stable(mem_req_line_o)))
        else $error("memory request changed before it was accepted");

endmodule

// File: llc_msg_pkg.sv
package llc_msg_pkg;

    localparam int req_id_bits = 4;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } req_op_t;

    typedef logic [req_id_bits-1:0] req_id_t;

    // Controller walk, one bit changes per step
    typedef enum logic [2:0] {
        st_decode   = 3'b000,
        st_read_set = 3'b001,
        st_read_mem = 3'b011,
        st_lookup   = 3'b010,
        st_process  = 3'b110,
        st_update   = 3'b100
    } llc_state_t;

endpackage

// File: llc_patterns.txt
// kind(0 read, 1 write, 2 reset) _ line address _ line (word 3 first) _ id _ rsp stall cycles
// _ expected memory reads _ expected memory writes, all hex
0_015_00000000_00000000_00000000_00000000_1_2_1_0
1_023_a3a3a3a3_a2a2a2a2_a1a1a1a1_a0a0a0a0_2_1_0_0
0_023_00000000_00000000_00000000_00000000_3_0_0_0
1_107_d3000107_d2000107_d1000107_d0000107_4_0_0_0
1_207_d3000207_d2000207_d1000207_d0000207_5_0_0_0
1_307_d3000307_d2000307_d1000307_d0000307_6_0_0_0
1_407_d3000407_d2000407_d1000407_d0000407_7_0_0_0
1_507_d3000507_d2000507_d1000507_d0000507_8_0_0_1
0_107_00000000_00000000_00000000_00000000_9_0_1_1
0_109_00000000_00000000_00000000_00000000_a_0_1_0
0_209_00000000_00000000_00000000_00000000_b_0_1_0
0_309_00000000_00000000_00000000_00000000_c_0_1_0
0_409_00000000_00000000_00000000_00000000_d_0_1_0
0_509_00000000_00000000_00000000_00000000_e_2_1_0
0_509_00000000_00000000_00000000_00000000_f_4_0_0
2_000_00000000_00000000_00000000_00000000_0_0_0_0
0_023_00000000_00000000_00000000_00000000_1_0_1_0

// File: llc_set_mem.sv
`timescale 1ns/1ps

module llc_set_mem (
    input  logic                                              clk,
    input  logic                                              rst,
    input  llc_msg_pkg::llc_state_t                           state_i,
    input  llc_cfg_pkg::llc_set_t                             set_i,
    input  llc_cfg_pkg::llc_tag_t [llc_cfg_pkg::llc_ways-1:0] wr_tag_i,
    input  logic [llc_cfg_pkg::llc_ways-1:0]                  wr_valid_i,
    input  logic [llc_cfg_pkg::llc_ways-1:0]                  wr_dirty_i,
    input  llc_cfg_pkg::line_t [llc_cfg_pkg::llc_ways-1:0]    wr_line_i,
    input  logic                                              repl_i,
    output llc_cfg_pkg::llc_tag_t [llc_cfg_pkg::llc_ways-1:0] rd_tag_o,
    output logic [llc_cfg_pkg::llc_ways-1:0]                  rd_valid_o,
    output logic [llc_cfg_pkg::llc_ways-1:0]                  rd_dirty_o,
    output llc_cfg_pkg::line_t [llc_cfg_pkg::llc_ways-1:0]    rd_line_o,
    output llc_cfg_pkg::llc_way_t                             rd_evict_o
);
    import llc_cfg_pkg::*;
    import llc_msg_pkg::*;

    llc_tag_t [llc_ways-1:0] tag_mem   [llc_sets];
    line_t    [llc_ways-1:0] line_mem  [llc_sets];
    logic     [llc_ways-1:0] dirty_mem [llc_sets];
    logic     [llc_ways-1:0] valid_mem [llc_sets];
    llc_way_t                evict_mem [llc_sets];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < llc_sets; s++) begin
                valid_mem[s] <= '0;
                evict_mem[s] <= '0;
            end
        end else if (state_i == st_update) begin
            valid_mem[set_i] <= wr_valid_i;
            // A full set means the victim was the pointer's way
            if (repl_i && (&rd_valid_o)) begin
                evict_mem[set_i] <= evict_mem[set_i] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_i == st_update) begin
            tag_mem[set_i]   <= wr_tag_i;
            dirty_mem[set_i] <= wr_dirty_i;
            line_mem[set_i]  <= wr_line_i;
        end
    end

    always_ff @(posedge clk) begin
        if (state_i == st_read_set) begin
            rd_tag_o   <= tag_mem[set_i];
            rd_valid_o <= valid_mem[set_i];
            rd_dirty_o <= dirty_mem[set_i];
            rd_line_o  <= line_mem[set_i];
            rd_evict_o <= evict_mem[set_i];
        end
    end

endmodule

// File: llc_top.sv
`timescale 1ns/1ps

module llc_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  llc_msg_pkg::req_op_t    req_op_i,
    input  llc_cfg_pkg::line_addr_t req_addr_i,
    input  llc_cfg_pkg::line_t      req_line_i,
    input  llc_msg_pkg::req_id_t    req_id_i,
    output logic                    rsp_valid_o,
    input  logic                    rsp_ready_i,
    output llc_cfg_pkg::line_t      rsp_line_o,
    output llc_msg_pkg::req_id_t    rsp_id_o,
    output logic                    mem_req_valid_o,
    input  logic                    mem_req_ready_i,
    output logic                    mem_req_write_o,
    output llc_cfg_pkg::line_addr_t mem_req_addr_o,
    output llc_cfg_pkg::line_t      mem_req_line_o,
    input  logic                    mem_rsp_valid_i,
    output logic                    mem_rsp_ready_o,
    input  llc_cfg_pkg::line_t      mem_rsp_line_i
);
    import llc_cfg_pkg::*;
    import llc_msg_pkg::*;

    llc_state_t state;
    llc_set_t   set;
    llc_tag_t   tag;
    llc_way_t   way;
    logic       buf_wr;
    line_t      buf_wr_line;
    logic       buf_wr_dirty;
    logic       fill;
    logic       hit;
    llc_way_t   hit_way;
    llc_way_t   victim_way;
    logic       victim_dirty;
    logic       repl;

    llc_tag_t [llc_ways-1:0] rd_tag;
    logic     [llc_ways-1:0] rd_valid;
    logic     [llc_ways-1:0] rd_dirty;
    line_t    [llc_ways-1:0] rd_line;
    llc_way_t                rd_evict;

    llc_tag_t [llc_ways-1:0] buf_tag;
    logic     [llc_ways-1:0] buf_valid;
    logic     [llc_ways-1:0] buf_dirty;
    line_t    [llc_ways-1:0] buf_line;
    llc_way_t                buf_evict;

    llc_ctrl u_ctrl (
        .clk, .rst,
        .req_valid_i, .req_ready_o, .req_op_i, .req_addr_i, .req_line_i, .req_id_i,
        .rsp_valid_o, .rsp_ready_i, .rsp_line_o, .rsp_id_o,
        .mem_req_valid_o, .mem_req_ready_i, .mem_req_write_o, .mem_req_addr_o,
        .mem_req_line_o, .mem_rsp_valid_i, .mem_rsp_ready_o,
        .state_o(state), .set_o(set), .tag_o(tag), .way_o(way),
        .buf_wr_o(buf_wr), .buf_wr_line_o(buf_wr_line), .buf_wr_dirty_o(buf_wr_dirty),
        .fill_o(fill),
        .hit_i(hit), .hit_way_i(hit_way), .victim_way_i(victim_way),
        .victim_dirty_i(victim_dirty),
        .buf_tag_i(buf_tag[way]), .buf_line_i(buf_line[way]),  // Selected way only
        .repl_o(repl)
    );

    llc_set_mem u_set_mem (
        .clk, .rst, .state_i(state), .set_i(set),
        .wr_tag_i(buf_tag), .wr_valid_i(buf_valid), .wr_dirty_i(buf_dirty),
        .wr_line_i(buf_line), .repl_i(repl),
        .rd_tag_o(rd_tag), .rd_valid_o(rd_valid), .rd_dirty_o(rd_dirty),
        .rd_line_o(rd_line), .rd_evict_o(rd_evict)
    );

    llc_way_buf u_way_buf (
        .clk, .rst, .state_i(state), .way_i(way),
        .rd_tag_i(rd_tag), .rd_valid_i(rd_valid), .rd_dirty_i(rd_dirty),
        .rd_line_i(rd_line), .rd_evict_i(rd_evict),
        .wr_i(buf_wr), .wr_tag_i(tag), .wr_line_i(buf_wr_line), .wr_dirty_i(buf_wr_dirty),
        .fill_i(fill), .fill_line_i(mem_rsp_line_i),
        .buf_tag_o(buf_tag), .buf_valid_o(buf_valid), .buf_dirty_o(buf_dirty),
        .buf_line_o(buf_line), .buf_evict_o(buf_evict)
    );

    llc_way_lookup u_way_lookup (
        .tag_i(tag), .buf_tag_i(buf_tag), .buf_valid_i(buf_valid),
        .buf_dirty_i(buf_dirty), .buf_evict_i(buf_evict),
        .hit_o(hit), .hit_way_o(hit_way), .victim_way_o(victim_way),
        .victim_dirty_o(victim_dirty)
    );

endmodule

// File: llc_way_buf.sv
`timescale 1ns/1ps

module llc_way_buf (
    input  logic                                              clk,
    input  logic                                              rst,
    input  llc_msg_pkg::llc_state_t                           state_i,
    input  llc_cfg_pkg::llc_way_t                             way_i,
    input  llc_cfg_pkg::llc_tag_t [llc_cfg_pkg::llc_ways-1:0] rd_tag_i,
    input  logic [llc_cfg_pkg::llc_ways-1:0]                  rd_valid_i,
    input  logic [llc_cfg_pkg::llc_ways-1:0]                  rd_dirty_i,
    input  llc_cfg_pkg::line_t [llc_cfg_pkg::llc_ways-1:0]    rd_line_i,
    input  llc_cfg_pkg::llc_way_t                             rd_evict_i,
    input  logic                                              wr_i,
    input  llc_cfg_pkg::llc_tag_t                             wr_tag_i,
    input  llc_cfg_pkg::line_t                                wr_line_i,
    input  logic                                              wr_dirty_i,
    input  logic                                              fill_i,
    input  llc_cfg_pkg::line_t                                fill_line_i,
    output llc_cfg_pkg::llc_tag_t [llc_cfg_pkg::llc_ways-1:0] buf_tag_o,
    output logic [llc_cfg_pkg::llc_ways-1:0]                  buf_valid_o,
    output logic [llc_cfg_pkg::llc_ways-1:0]                  buf_dirty_o,
    output llc_cfg_pkg::line_t [llc_cfg_pkg::llc_ways-1:0]    buf_line_o,
    output llc_cfg_pkg::llc_way_t                             buf_evict_o
);
    import llc_msg_pkg::*;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            buf_valid_o <= '0;
            buf_evict_o <= '0;
        end else if (state_i == st_read_mem) begin
            buf_valid_o <= rd_valid_i;
            buf_evict_o <= rd_evict_i;
        end else if (wr_i) begin
            buf_valid_o[way_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state_i == st_read_mem) begin
            buf_tag_o   <= rd_tag_i;
            buf_dirty_o <= rd_dirty_i;
            buf_line_o  <= rd_line_i;
        end else if (fill_i) begin
            buf_line_o[way_i] <= fill_line_i;  // Tag follows with the write strobe
        end else if (wr_i) begin
            buf_tag_o[way_i]   <= wr_tag_i;
            buf_dirty_o[way_i] <= wr_dirty_i;
            buf_line_o[way_i]  <= wr_line_i;
        end
    end

    a_fill_wr_excl: assert property (@(posedge clk) disable iff (!rst) !(fill_i && wr_i))
        else $error("fill and buffer write in the same cycle");

endmodule

// File: llc_way_lookup.sv
`timescale 1ns/1ps

module llc_way_lookup (
    input  llc_cfg_pkg::llc_tag_t                             tag_i,
    input  llc_cfg_pkg::llc_tag_t [llc_cfg_pkg::llc_ways-1:0] buf_tag_i,
    input  logic [llc_cfg_pkg::llc_ways-1:0]                  buf_valid_i,
    input  logic [llc_cfg_pkg::llc_ways-1:0]                  buf_dirty_i,
    input  llc_cfg_pkg::llc_way_t                             buf_evict_i,
    output logic                                              hit_o,
    output llc_cfg_pkg::llc_way_t                             hit_way_o,
    output llc_cfg_pkg::llc_way_t                             victim_way_o,
    output logic                                              victim_dirty_o
);
    import llc_cfg_pkg::*;

    logic [llc_ways-1:0] match;

    // Walk downwards so the lowest matching or free way wins
    always_comb begin
        hit_way_o    = '0;
        victim_way_o = buf_evict_i;
        for (int w = llc_ways - 1; w >= 0; w--) begin
            match[w] = buf_valid_i[w] && (buf_tag_i[w] == tag_i);
            if (match[w]) hit_way_o = llc_way_t'(w);
            if (!buf_valid_i[w]) victim_way_o = llc_way_t'(w);
        end
    end

    assign hit_o          = |match;
    assign victim_dirty_o = buf_valid_i[victim_way_o] && buf_dirty_i[victim_way_o];

    // Two valid copies of one tag would mean the buffer update went wrong
    always_comb begin
        a_single_match: assert final ($isunknown(match) || $onehot0(match))
            else $error("tag present in more than one valid way");
    end

endmodule

// File: tb_llc.sv
`timescale 1ns/1ps

module tb_llc;
    import llc_cfg_pkg::*;
    import llc_msg_pkg::*;

    logic       clk = 1'b0;
    logic       rst = 1'b0;
    logic       req_valid_i = 1'b0;
    logic       req_ready_o;
    req_op_t    req_op_i = op_read;
    line_addr_t req_addr_i = '0;
    line_t      req_line_i = '0;
    req_id_t    req_id_i = '0;
    logic       rsp_valid_o;
    logic       rsp_ready_i = 1'b0;
    line_t      rsp_line_o;
    req_id_t    rsp_id_o;
    logic       mem_req_valid_o;
    logic       mem_req_ready_i = 1'b0;
    logic       mem_req_write_o;
    line_addr_t mem_req_addr_o;
    line_t      mem_req_line_o;
    logic       mem_rsp_valid_i = 1'b0;
    logic       mem_rsp_ready_o;
    line_t      mem_rsp_line_i = '0;

    logic [159:0] pats [32];  // Kind, addr, line, id, stall, mem reads, mem writes
    int           n_pat;
    int           checks = 0;
    int           errors = 0;
    int           cycles = 0;
    int           limit_cycles;
    integer       seed = 32'h7698_cb2a;

    line_t      mem_data [line_addr_t];  // Memory behind the cache
    line_t      image [line_addr_t];     // Last value the requester wrote
    llc_tag_t   m_tag [llc_sets][llc_ways];
    logic       m_valid [llc_sets][llc_ways];
    logic       m_dirty [llc_sets][llc_ways];
    int         m_ptr [llc_sets];
    logic       wb_expected = 1'b0;
    line_addr_t exp_wb_addr;
    line_t      exp_wb_line;
    line_addr_t cur_addr;
    int         rd_count;
    int         wr_count;
    logic       fill_pend = 1'b0;
    int         fill_delay;
    line_t      fill_line;

    llc_top i_dut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit_cycles) begin
            $display("Timeout: the DUT did not finish the patterns within %0d cycles", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic line_t initial_line(line_addr_t addr);
        line_t l;
        for (int w = 0; w < 4; w++) l[w*32 +: 32] = {16'(addr), 16'(w)};
        return l;
    endfunction

    function automatic line_t expected_line(line_addr_t addr);
        return image.exists(addr) ? image[addr] : initial_line(addr);
    endfunction

    task automatic compare_value(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Hit, else lowest free way, else the set's pointer which then moves on
    task automatic predict_cache(input req_op_t op, input line_addr_t addr);
        line_addr_u a;
        line_addr_u victim;
        int         hit_w;
        int         vic;
        a.raw = addr;
        hit_w = -1;
        vic = -1;
        for (int w = llc_ways - 1; w >= 0; w--) begin
            if (m_valid[a.f.set][w] && m_tag[a.f.set][w] == a.f.tag) hit_w = w;
            if (!m_valid[a.f.set][w]) vic = w;
        end
        if (hit_w >= 0) begin
            if (op == op_write) m_dirty[a.f.set][hit_w] = 1'b1;
        end else begin
            if (vic < 0) begin
                vic = m_ptr[a.f.set];
                m_ptr[a.f.set] = (m_ptr[a.f.set] + 1) % llc_ways;
            end
            if (m_valid[a.f.set][vic] && m_dirty[a.f.set][vic]) begin
                victim.f.tag = m_tag[a.f.set][vic];
                victim.f.set = a.f.set;
                wb_expected = 1'b1;
                exp_wb_addr = victim.raw;
                exp_wb_line = expected_line(victim.raw);
            end
            m_valid[a.f.set][vic] = 1'b1;
            m_tag[a.f.set][vic] = a.f.tag;
            m_dirty[a.f.set][vic] = (op == op_write);
        end
    endtask

    task automatic apply_reset();
        rst <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        for (int s = 0; s < llc_sets; s++) begin
            m_ptr[s] = 0;
            for (int w = 0; w < llc_ways; w++) m_valid[s][w] = 1'b0;
        end
        image = mem_data;  // Dirty lines still in the cache are lost
    endtask

    task automatic run_pattern(input int idx);
        logic [159:0] p;
        req_op_t      op;
        line_addr_t   addr;
        line_t        exp_line;
        line_t        got_line;
        req_id_t      got_id;
        int           stall;
        int           err_before;
        string        kind;
        p = pats[idx];
        op = req_op_t'(p[156]);
        addr = p[155:144];
        stall = int'(p[11:8]);
        err_before = errors;
        kind = (p[159:156] == 4'h2) ? "reset" : (op == op_write) ? "write" : "read";
        if (p[159:156] == 4'h2) begin
            apply_reset();
        end else begin
            exp_line = (op == op_write) ? '0 : expected_line(addr);
            predict_cache(op, addr);
            if (op == op_write) image[addr] = p[143:16];
            rd_count = 0;
            wr_count = 0;
            cur_addr = addr;
            req_valid_i <= 1'b1;
            req_op_i <= op;
            req_addr_i <= addr;
            req_line_i <= p[143:16];
            req_id_i <= p[15:12];
            do @(posedge clk); while (!req_ready_o);
            req_valid_i <= 1'b0;
            rsp_ready_i <= (stall == 0);
            do @(posedge clk); while (!rsp_valid_o);
            got_line = rsp_line_o;
            got_id = rsp_id_o;
            for (int k = 0; k < stall; k++) begin
                if (k == stall - 1) rsp_ready_i <= 1'b1;
                @(posedge clk);
                compare_value("rsp_valid_o", rsp_valid_o, 1);
                compare_value("rsp_line_o", rsp_line_o, got_line);
                compare_value("rsp_id_o", rsp_id_o, got_id);
                compare_value("req_ready_o", req_ready_o, 0);
            end
            rsp_ready_i <= 1'b0;
            compare_value("rsp_line_o", got_line, exp_line);
            compare_value("rsp_id_o", got_id, p[15:12]);
            compare_value("memory read count", rd_count, p[7:4]);
            compare_value("memory write count", wr_count, p[3:0]);
        end
        $display("pattern %0d %s %h: %s", idx, kind, addr,
                 (errors == err_before) ? "ok" : "FAILED");
    endtask

    // Memory with random request stalls and fill delays
    always @(posedge clk) begin
        if (rst) begin
            compare_value("mem_rsp_ready_o", mem_rsp_ready_o, fill_pend);
        end
        mem_req_ready_i <= ($random(seed) & 1) != 0;
        if (mem_rsp_valid_i && mem_rsp_ready_o) begin
            mem_rsp_valid_i <= 1'b0;
            fill_pend = 1'b0;
        end else if (fill_pend) begin
            if (fill_delay > 0) begin
                fill_delay--;
            end else begin
                mem_rsp_valid_i <= 1'b1;
                mem_rsp_line_i <= fill_line;
            end
        end
        if (mem_req_valid_o && mem_req_ready_i) begin
            if (mem_req_write_o) begin
                wr_count++;
                assert (wb_expected)
                else begin
                    errors++;
                    $display("Memory write to %h at %0t ns was not expected", mem_req_addr_o,
                             $time);
                end
                compare_value("mem_req_addr_o", mem_req_addr_o, exp_wb_addr);
                compare_value("mem_req_line_o", mem_req_line_o, exp_wb_line);
                mem_data[mem_req_addr_o] = mem_req_line_o;
                wb_expected = 1'b0;
            end else begin
                rd_count++;
                compare_value("mem_req_addr_o", mem_req_addr_o, cur_addr);
                fill_line = mem_data.exists(mem_req_addr_o) ? mem_data[mem_req_addr_o]
                                                             : initial_line(mem_req_addr_o);
                fill_pend = 1'b1;
                fill_delay = $random(seed) & 3;
            end
        end
    end

    initial begin
        for (int i = 0; i < 32; i++) pats[i] = '1;  // Unread entries end the list
        $readmemh("llc_patterns.txt", pats);
        n_pat = 0;
        while (n_pat < 32 && pats[n_pat][159:156] != 4'hf) n_pat++;
        limit_cycles = 64 * (n_pat + 1);
        apply_reset();
        for (int i = 0; i < n_pat; i++) run_pattern(i);
        assert (n_pat > 0)
        else begin
            errors++;
            $display("No patterns were read from llc_patterns.txt");
        end
        $display("%0d patterns, %0d checks, %0d errors", n_pat, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: verilog.f
llc_cfg_pkg.sv
llc_msg_pkg.sv
llc_way_lookup.sv
llc_way_buf.sv
llc_set_mem.sv
llc_ctrl.sv
llc_top.sv
tb_llc.sv
